/* cu_pkg.sv */
package cu_pkg;

	typedef enum logic [2:0] {
		CYC_FETCH,	// PC out to MAR, PC + 2 set up
		CYC_FETCH_PC,	// Incremented PC written back
		CYC_FETCH_IR,	// MDR into IR
		CYC_DECODE,	// Decoder enable or CEX skip
		CYC_EXEC1,
		CYC_EXEC2,	// SWAP only
		CYC_EXEC3,	// SWAP only
		CYC_BRK_HALT	// Parked while PC sits on the breakpoint
	} cycle_t;

	// Opcode numbers follow the decoder, gaps are invalid
	typedef enum logic [6:0] {
		OP_BEQ = 7'd1, OP_BNE = 7'd2, OP_BC = 7'd3, OP_BNC = 7'd4,
		OP_BN = 7'd5, OP_BGE = 7'd6, OP_BLT = 7'd7, OP_BRA = 7'd8,
		OP_ADD = 7'd9, OP_ADDC = 7'd10, OP_SUB = 7'd11, OP_SUBC = 7'd12,
		OP_DADD = 7'd13, OP_CMP = 7'd14, OP_XOR = 7'd15, OP_AND = 7'd16,
		OP_OR = 7'd17, OP_BIT = 7'd18, OP_BIC = 7'd19, OP_BIS = 7'd20,
		OP_MOV = 7'd21, OP_SWAP = 7'd22, OP_SRA = 7'd23, OP_RRC = 7'd24,
		OP_SETCC = 7'd30, OP_CLRCC = 7'd31, OP_CEX = 7'd32
	} op_t;

	// Word encodings, byte variant is the next odd value
	typedef enum logic [5:0] {
		ALU_ADD = 6'd0, ALU_ADDC = 6'd2, ALU_SUB = 6'd4, ALU_SUBC = 6'd6,
		ALU_DADD = 6'd8, ALU_CMP = 6'd10, ALU_XOR = 6'd12, ALU_AND = 6'd14,
		ALU_OR = 6'd16, ALU_BIT = 6'd18, ALU_BIC = 6'd20, ALU_BIS = 6'd22,
		ALU_SRA = 6'd24, ALU_RRC = 6'd26
	} alu_op_t;

	typedef enum logic [1:0] {SRC_MDR, SRC_REG, SRC_IR, SRC_ALU} bus_src_t;
	typedef enum logic [1:0] {DST_MDR, DST_REG, DST_IR, DST_ALU} bus_dst_t;	// DST_MDR is MAR on addr bus

	typedef enum logic [1:0] {PSW_PASS, PSW_SET, PSW_CLR} psw_op_t;

	typedef struct packed {
		logic wb;	// 1 = byte transfer
		bus_src_t src;
		bus_dst_t dst;
		logic en;	// Route active this cycle
	} bus_route_t;

	typedef struct packed {
		op_t op;
		logic [2:0] dst;
		logic [2:0] src;
		logic rc;	// Constant table select
		logic wb;
		logic [3:0] cond;	// CEX condition code
		logic [2:0] t_cnt;
		logic [2:0] f_cnt;
		logic [4:0] pswb;	// SETCC/CLRCC mask
	} decoded_instr_t;

	typedef struct packed {
		logic id_en;
		logic mem_ena;
		logic mem_write;
		logic mem_byte;
		bus_route_t addr_route;
		bus_route_t data_route;
		logic [4:0] dbus_dst;
		logic [4:0] dbus_src;
		logic [4:0] alu_dst;
		logic [4:0] alu_src;
		logic [4:0] addr_src;
		logic s_bus_sel;	// 0 = reg file, 1 = sign-extended offset
		logic [4:0] sxt_bit_num;
		logic sxt_shift;
		alu_op_t alu_op;
		logic psw_update;
	} ctrl_word_t;

	typedef struct packed {
		logic active;
		logic result;	// Condition outcome at CEX
		logic [2:0] t_cnt;
		logic [2:0] f_cnt;
	} cex_state_t;

	localparam logic [4:0] REG_PC = 5'd7;
	localparam logic [4:0] REG_CONST_2 = 5'd10;	// Constant 2 in the table
	localparam logic [4:0] REG_TEMP = 5'd16;

	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 4;

endpackage

/* condition_eval.sv */
module condition_eval (
	input  logic [4:0] flags,
	input  logic [3:0] code,
	output logic cond_true
);
	import cu_pkg::*;

	logic c;
	logic z;
	logic n;
	logic v;

	assign c = flags[FLAG_C];	// Carry
	assign z = flags[FLAG_Z];	// Zero
	assign n = flags[FLAG_N];	// Negative
	assign v = flags[FLAG_V];	// Overflow

	always_comb
	begin
		case (code)
			4'd0: cond_true = z;	// EQ
			4'd1: cond_true = !z;	// NE
			4'd2: cond_true = c;	// CS/HS
			4'd3: cond_true = !c;	// CC/LO
			4'd4: cond_true = n;	// MI
			4'd5: cond_true = !n;	// PL
			4'd6: cond_true = v;	// VS
			4'd7: cond_true = !v;	// VC
			4'd8: cond_true = c && !z;	// HI
			4'd9: cond_true = !c || z;	// LS
			4'd10: cond_true = (n == v);	// GE
			4'd11: cond_true = (n != v);	// LT
			4'd12: cond_true = !z && (n == v);	// GT
			4'd13: cond_true = z || (n != v);	// LE
			4'd14: cond_true = 1'b1;	// AL
			default: cond_true = 1'b0;	// Never
		endcase
	end

endmodule

/* cex_tracker.sv */
module cex_tracker (
	input  logic clock,
	input  logic cpucycle_rst,
	input  cu_pkg::cycle_t cycle,
	input  logic cex_load,
	input  cu_pkg::cex_state_t cex_next,
	output logic exec_ok,
	output cu_pkg::cex_state_t cex_state
);
	import cu_pkg::*;

	cex_state_t dec_state;	// State after one decode
	logic [2:0] t_left;
	logic [2:0] f_left;

	// True block runs first, then the false block
	assign exec_ok = !cex_state.active
		|| (cex_state.result && (cex_state.t_cnt != 3'd0))
		|| (!cex_state.result && (cex_state.f_cnt != 3'd0) && (cex_state.t_cnt == 3'd0));

	always_comb
	begin
		t_left = cex_state.t_cnt;
		f_left = cex_state.f_cnt;
		if (t_left != 3'd0)
			t_left = t_left - 3'd1;	// Count true side first
		else if (f_left != 3'd0)
			f_left = f_left - 3'd1;
		dec_state.active = cex_state.active && ((t_left != 3'd0) || (f_left != 3'd0));
		dec_state.result = cex_state.result;
		dec_state.t_cnt = t_left;
		dec_state.f_cnt = f_left;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			cex_state <= '0;
		else if (cex_load)
			cex_state <= cex_next;	// New CEX from EXEC1
		else if (cycle == CYC_DECODE)
			cex_state <= dec_state;
	end

	a_load_not_decode: assert property (@(posedge clock) disable iff (cpucycle_rst)
		cex_load |-> (cycle != CYC_DECODE))
		else $error("CEX load collides with decode countdown");

endmodule

/* cycle_sequencer.sv */
module cycle_sequencer #(
	parameter int ADDR_W = 16
) (
	input  logic clock,
	input  logic cpucycle_rst,
	input  logic instr_done,
	input  logic [ADDR_W-1:0] pc,
	input  logic [ADDR_W-1:0] brkpnt,
	output cu_pkg::cycle_t cycle
);
	import cu_pkg::*;

	cycle_t cycle_next;
	cycle_t end_state;	// Where an instruction ends up

	assign end_state = (pc == brkpnt) ? CYC_BRK_HALT : CYC_FETCH;

	always_comb
	begin
		cycle_next = cycle;
		case (cycle)
			CYC_FETCH, CYC_FETCH_PC, CYC_FETCH_IR:
				cycle_next = cycle_t'(cycle + 3'd1);	// Fetch always runs through
			CYC_DECODE, CYC_EXEC1, CYC_EXEC2:
				cycle_next = instr_done ? end_state : cycle_t'(cycle + 3'd1);
			CYC_EXEC3:
				cycle_next = end_state;	// Longest instruction
			CYC_BRK_HALT:
				cycle_next = (pc != brkpnt) ? CYC_FETCH : CYC_BRK_HALT;
			default:
				cycle_next = CYC_FETCH;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			cycle <= CYC_FETCH;
		else
			cycle <= cycle_next;
	end

	a_done_in_exec: assert property (@(posedge clock) disable iff (cpucycle_rst)
		instr_done |-> (cycle inside {CYC_DECODE, CYC_EXEC1, CYC_EXEC2, CYC_EXEC3}))
		else $error("instr_done raised outside decode or execute");

	a_exec3_ends: assert property (@(posedge clock) disable iff (cpucycle_rst)
		(cycle == CYC_EXEC3) |-> instr_done)
		else $error("EXEC3 reached without end of instruction");

endmodule

/* psw_unit.sv */
module psw_unit #(
	parameter logic [15:0] PSW_INIT = 16'h60e0
) (
	input  logic clock,
	input  logic cpucycle_rst,
	input  logic [15:0] psw_in,
	input  cu_pkg::psw_op_t psw_op,
	input  logic [4:0] psw_mask,
	output logic [15:0] psw_out
);
	import cu_pkg::*;

	logic [4:0] flags_next;

	always_comb
	begin
		case (psw_op)
			PSW_SET: flags_next = psw_in[4:0] | psw_mask;	// SETCC
			PSW_CLR: flags_next = psw_in[4:0] & ~psw_mask;	// CLRCC
			default: flags_next = psw_in[4:0];	// Track datapath PSW
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw_out <= PSW_INIT;
		else
			psw_out <= {psw_in[15:5], flags_next};	// Upper bits pass unchanged
	end

endmodule

/* exec_control.sv */
module exec_control (
	input  logic clock,
	input  logic cpucycle_rst,
	input  cu_pkg::cycle_t cycle,
	input  cu_pkg::decoded_instr_t instr,
	input  logic [4:0] flags,
	input  logic exec_ok,
	output cu_pkg::ctrl_word_t ctrl,
	output logic instr_done,
	output cu_pkg::psw_op_t psw_op,
	output logic [4:0] psw_mask,
	output logic cex_load,
	output cu_pkg::cex_state_t cex_next
);
	import cu_pkg::*;

	decoded_instr_t instr_q;	// Held through execute
	logic [3:0] cond_code;
	logic cond_true;
	logic [4:0] alu_idx;	// ALU op without the byte bit
	logic [4:0] dst_reg;
	logic [4:0] src_reg;

	function automatic bus_route_t route(input logic wb, input bus_src_t src,
		input bus_dst_t dst);
		return '{wb: wb, src: src, dst: dst, en: 1'b1};
	endfunction

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			instr_q <= '0;	// Opcode 0 is invalid
		else if ((cycle == CYC_DECODE) && exec_ok)
			instr_q <= instr;
	end

	assign dst_reg = {2'b00, instr_q.dst};
	assign src_reg = {2'b00, instr_q.src};
	assign alu_idx = (instr_q.op inside {OP_SRA, OP_RRC}) ? 5'(instr_q.op - 7'd11)
		: 5'(instr_q.op - OP_ADD);

	// Branch opcodes map onto the shared condition table
	always_comb
	begin
		if (instr_q.op == OP_CEX)
			cond_code = instr_q.cond;
		else if (instr_q.op <= OP_BN)
			cond_code = 4'(instr_q.op - 7'd1);
		else
			cond_code = 4'(instr_q.op + 7'd4);
	end

	condition_eval u_cond (
		.flags(flags),
		.code(cond_code),
		.cond_true(cond_true)
	);

	always_comb
	begin
		ctrl = '0;	// Every enable idle by default
		instr_done = 1'b0;
		psw_op = PSW_PASS;
		psw_mask = '0;
		cex_load = 1'b0;
		cex_next = '0;
		case (cycle)
			CYC_FETCH:
			begin
				ctrl.addr_src = REG_PC;
				ctrl.addr_route = route(1'b0, SRC_REG, DST_MDR);	// PC to MAR
				ctrl.mem_ena = 1'b1;	// Word read
				ctrl.alu_dst = REG_PC;
				ctrl.alu_src = REG_CONST_2;
				ctrl.alu_op = ALU_ADD;	// PC + 2, flags untouched
			end
			CYC_FETCH_PC:
			begin
				ctrl.alu_dst = REG_PC;
				ctrl.alu_src = REG_CONST_2;
				ctrl.dbus_dst = REG_PC;
				ctrl.data_route = route(1'b0, SRC_ALU, DST_REG);
			end
			CYC_FETCH_IR:
				ctrl.data_route = route(1'b0, SRC_MDR, DST_IR);
			CYC_DECODE:
			begin
				ctrl.id_en = exec_ok;
				instr_done = !exec_ok;	// CEX skip
			end
			CYC_EXEC1:
			begin
				instr_done = (instr_q.op != OP_SWAP);
				case (instr_q.op) inside
					[OP_BEQ:OP_BRA]:
						if (cond_true)
						begin
							ctrl.s_bus_sel = 1'b1;	// Offset on S-bus
							ctrl.sxt_bit_num = 5'd10;
							ctrl.sxt_shift = 1'b1;	// Word offset
							ctrl.alu_op = ALU_ADD;
							ctrl.alu_dst = REG_PC;
							ctrl.dbus_dst = REG_PC;
							ctrl.data_route = route(1'b0, SRC_ALU, DST_REG);
						end
					[OP_ADD:OP_BIS], OP_SRA, OP_RRC:
					begin
						ctrl.alu_op = alu_op_t'({alu_idx, instr_q.wb});
						ctrl.alu_dst = dst_reg;
						ctrl.alu_src = {1'b0, instr_q.rc, instr_q.src};	// rc picks constants
						ctrl.dbus_dst = dst_reg;
						ctrl.psw_update = 1'b1;
						ctrl.data_route = route(instr_q.wb, SRC_ALU, DST_REG);
					end
					OP_MOV:
					begin
						ctrl.dbus_dst = dst_reg;
						ctrl.dbus_src = src_reg;
						ctrl.data_route = route(instr_q.wb, SRC_REG, DST_REG);
					end
					OP_SWAP:
					begin
						ctrl.dbus_dst = REG_TEMP;	// Park src
						ctrl.dbus_src = src_reg;
						ctrl.data_route = route(1'b0, SRC_REG, DST_REG);
					end
					OP_SETCC, OP_CLRCC:
					begin
						psw_op = (instr_q.op == OP_SETCC) ? PSW_SET : PSW_CLR;
						psw_mask = instr_q.pswb;
					end
					OP_CEX:
					begin
						cex_load = 1'b1;
						cex_next = '{active: 1'b1, result: cond_true,
							t_cnt: instr_q.t_cnt, f_cnt: instr_q.f_cnt};
					end
					default:
						instr_done = 1'b1;	// Invalid, no action
				endcase
			end
			CYC_EXEC2:
			begin
				ctrl.dbus_dst = src_reg;	// dst into src
				ctrl.dbus_src = dst_reg;
				ctrl.data_route = route(1'b0, SRC_REG, DST_REG);
			end
			CYC_EXEC3:
			begin
				instr_done = 1'b1;
				ctrl.dbus_dst = dst_reg;	// Temp into dst
				ctrl.dbus_src = REG_TEMP;
				ctrl.data_route = route(1'b0, SRC_REG, DST_REG);
			end
			default:
				ctrl = '0;	// Breakpoint halt
		endcase
	end

endmodule

/* control_unit.sv */
module control_unit #(
	parameter int ADDR_W = 16,
	parameter logic [15:0] PSW_INIT = 16'h60e0
) (
	input  logic clock,
	input  logic cpucycle_rst,
	input  cu_pkg::decoded_instr_t instr,
	input  logic [ADDR_W-1:0] pc,
	input  logic [ADDR_W-1:0] brkpnt,
	input  logic [15:0] psw_in,
	output cu_pkg::ctrl_word_t ctrl,
	output cu_pkg::cycle_t cycle,
	output logic [15:0] psw_out,
	output cu_pkg::cex_state_t cex_state
);
	import cu_pkg::*;

	logic instr_done;	// End of instruction
	logic exec_ok;
	psw_op_t psw_op;
	logic [4:0] psw_mask;
	logic cex_load;
	cex_state_t cex_next;

	cycle_sequencer #(.ADDR_W(ADDR_W)) u_seq (
		.clock, .cpucycle_rst,
		.instr_done, .pc, .brkpnt,
		.cycle
	);

	exec_control u_exec (
		.clock, .cpucycle_rst, .cycle, .instr,
		.flags(psw_in[4:0]),	// C Z N SLP V
		.exec_ok, .ctrl, .instr_done,
		.psw_op, .psw_mask,
		.cex_load, .cex_next
	);

	cex_tracker u_cex (
		.clock, .cpucycle_rst, .cycle,
		.cex_load, .cex_next,
		.exec_ok, .cex_state
	);

	psw_unit #(.PSW_INIT(PSW_INIT)) u_psw (
		.clock, .cpucycle_rst, .psw_in,
		.psw_op, .psw_mask,
		.psw_out
	);

endmodule

/* tb_control_unit.sv */
module tb_control_unit;
	timeunit 1ns;
	timeprecision 1ps;
	import cu_pkg::*;

	localparam int ADDR_W = 16;
	localparam logic [15:0] PSW_INIT = 16'h60e0;
	localparam int NUM_INSTR = 400;
	localparam int RESET_CYC = 8;
	localparam int INSTR_MAX_CYC = 7;	// SWAP is the longest
	localparam int HALT_MAX_CYC = 4;	// Halt hold plus release
	localparam int CYCLE_LIMIT = RESET_CYC + NUM_INSTR * (INSTR_MAX_CYC + HALT_MAX_CYC) + 200;

	logic clock;
	logic cpucycle_rst;
	decoded_instr_t instr;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] brkpnt;
	logic [15:0] psw_in;
	ctrl_word_t ctrl;
	cycle_t cycle;
	logic [15:0] psw_out;
	cex_state_t cex_state;

	cycle_t m_cycle;	// Model of the DUT state
	decoded_instr_t m_instr;
	cex_state_t m_cex;
	logic [15:0] m_psw;

	integer seed;
	int cycle_count;
	int instr_count;
	int halt_count;
	int err_cycle;
	int err_ctrl;
	int err_psw;
	int err_cex;
	int err_total;

	control_unit #(.ADDR_W(ADDR_W), .PSW_INIT(PSW_INIT)) UUT (
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.instr(instr),
		.pc(pc),
		.brkpnt(brkpnt),
		.psw_in(psw_in),
		.ctrl(ctrl),
		.cycle(cycle),
		.psw_out(psw_out),
		.cex_state(cex_state)
	);

	always #20 clock = ~clock;	// 40 ns period

	function automatic logic cond_holds(input logic [3:0] code, input logic [15:0] psw);
		logic c;
		logic z;
		logic n;
		logic v;
		c = psw[0];
		z = psw[1];
		n = psw[2];
		v = psw[4];	// Bit 3 is not a flag
		case (code)
			4'd0: return z;
			4'd1: return !z;
			4'd2: return c;
			4'd3: return !c;
			4'd4: return n;
			4'd5: return !n;
			4'd6: return v;
			4'd7: return !v;
			4'd8: return c && !z;
			4'd9: return !c || z;
			4'd10: return n == v;
			4'd11: return n != v;
			4'd12: return !z && (n == v);
			4'd13: return z || (n != v);
			4'd14: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [3:0] branch_code(input op_t op);
		if (op <= OP_BN)
			return 4'(int'(op) - 1);	// BEQ..BN map to 0..4
		else
			return 4'(int'(op) + 4);	// BGE, BLT, BRA map to 10..12
	endfunction

	function automatic logic cex_allows(input cex_state_t s);
		if (!s.active)
			return 1'b1;
		if (s.result)
			return s.t_cnt != 3'd0;
		return (s.f_cnt != 3'd0) && (s.t_cnt == 3'd0);
	endfunction

	function automatic cex_state_t cex_after_decode(input cex_state_t s);
		cex_state_t r;
		r = s;
		if (r.t_cnt != 3'd0)
			r.t_cnt = r.t_cnt - 3'd1;
		else if (r.f_cnt != 3'd0)
			r.f_cnt = r.f_cnt - 3'd1;
		if ((r.t_cnt == 3'd0) && (r.f_cnt == 3'd0))
			r.active = 1'b0;	// Both blocks used up
		return r;
	endfunction

	function automatic bus_route_t bus_path(input logic wb, input bus_src_t src,
		input bus_dst_t dst);
		bus_route_t p;
		p.wb = wb;
		p.src = src;
		p.dst = dst;
		p.en = 1'b1;
		return p;
	endfunction

	function automatic ctrl_word_t expected_ctrl(input cycle_t cyc, input decoded_instr_t ins,
		input logic ok, input logic [15:0] psw);
		ctrl_word_t w;
		int alu_idx;
		w = '0;
		case (cyc)
			CYC_FETCH:
			begin
				w.addr_src = REG_PC;
				w.addr_route = bus_path(1'b0, SRC_REG, DST_MDR);	// PC to MAR
				w.mem_ena = 1'b1;
				w.alu_dst = REG_PC;
				w.alu_src = REG_CONST_2;
				w.alu_op = ALU_ADD;
			end
			CYC_FETCH_PC:
			begin
				w.alu_dst = REG_PC;	// Adder still forms PC + 2
				w.alu_src = REG_CONST_2;
				w.dbus_dst = REG_PC;
				w.data_route = bus_path(1'b0, SRC_ALU, DST_REG);
			end
			CYC_FETCH_IR:
				w.data_route = bus_path(1'b0, SRC_MDR, DST_IR);
			CYC_DECODE:
				w.id_en = ok;
			CYC_EXEC1:
			begin
				if ((ins.op >= OP_BEQ) && (ins.op <= OP_BRA))
				begin
					if (cond_holds(branch_code(ins.op), psw))
					begin
						w.s_bus_sel = 1'b1;
						w.sxt_bit_num = 5'd10;
						w.sxt_shift = 1'b1;
						w.alu_op = ALU_ADD;
						w.alu_dst = REG_PC;
						w.dbus_dst = REG_PC;
						w.data_route = bus_path(1'b0, SRC_ALU, DST_REG);
					end
				end
				else if (((ins.op >= OP_ADD) && (ins.op <= OP_BIS))
					|| (ins.op == OP_SRA) || (ins.op == OP_RRC))
				begin
					if ((ins.op == OP_SRA) || (ins.op == OP_RRC))
						alu_idx = int'(ins.op) - 11;
					else
						alu_idx = int'(ins.op) - 9;
					w.alu_op = alu_op_t'(6'(2 * alu_idx + int'(ins.wb)));
					w.alu_dst = 5'(ins.dst);
					w.alu_src = 5'(ins.src) + (ins.rc ? 5'd8 : 5'd0);	// Constant table at 8
					w.dbus_dst = 5'(ins.dst);
					w.psw_update = 1'b1;
					w.data_route = bus_path(ins.wb, SRC_ALU, DST_REG);
				end
				else if (ins.op == OP_MOV)
				begin
					w.dbus_dst = 5'(ins.dst);
					w.dbus_src = 5'(ins.src);
					w.data_route = bus_path(ins.wb, SRC_REG, DST_REG);
				end
				else if (ins.op == OP_SWAP)
				begin
					w.dbus_dst = REG_TEMP;
					w.dbus_src = 5'(ins.src);
					w.data_route = bus_path(1'b0, SRC_REG, DST_REG);
				end
			end
			CYC_EXEC2:
			begin
				w.dbus_dst = 5'(ins.src);
				w.dbus_src = 5'(ins.dst);
				w.data_route = bus_path(1'b0, SRC_REG, DST_REG);
			end
			CYC_EXEC3:
			begin
				w.dbus_dst = 5'(ins.dst);
				w.dbus_src = REG_TEMP;
				w.data_route = bus_path(1'b0, SRC_REG, DST_REG);
			end
			default:
				w = '0;
		endcase
		return w;
	endfunction

	task automatic check_cycle(input string name, input cycle_t exp, input cycle_t act);
		if (act !== exp)
		begin
			err_cycle++;
			$display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
		if (act !== exp)
		begin
			err_ctrl++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_psw(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp)
		begin
			err_psw++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cex(input string name, input cex_state_t exp, input cex_state_t act);
		if (act !== exp)
		begin
			err_cex++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic draw_instruction();
		int r;
		logic [31:0] rnd;
		logic [31:0] rnd_psw;
		logic [31:0] rnd_pc;
		logic [6:0] op_val;
		r = $unsigned($random(seed)) % 32;
		rnd = $random(seed);
		rnd_psw = $random(seed);
		rnd_pc = $random(seed);
		if (r < 24)
			op_val = 7'(r + 1);	// Branches, ALU ops, MOV, SWAP, SRA, RRC
		else if (r < 26)
			op_val = 7'd30;
		else if (r < 28)
			op_val = 7'd31;
		else if (r < 30)
			op_val = 7'd32;
		else if (r == 30)
			op_val = 7'd25 + 7'($unsigned($random(seed)) % 5);	// Gap below SETCC
		else
			op_val = 7'd33 + 7'($unsigned($random(seed)) % 95);	// Above CEX
		instr = rnd[29:0];
		instr.op = op_t'(op_val);
		instr.t_cnt = 3'($unsigned($random(seed)) % 4);	// Short CEX blocks
		instr.f_cnt = 3'($unsigned($random(seed)) % 4);
		psw_in = rnd_psw[15:0];
		pc = rnd_pc[15:0];
		if (rnd_pc[31:28] == 4'd0)
			brkpnt = pc;	// Rare breakpoint hit
		else
			brkpnt = pc ^ {rnd_psw[31:17], 1'b1};
		halt_count = 0;
	endtask

	task automatic drive_inputs();
		if (m_cycle == CYC_FETCH)
		begin
			draw_instruction();
			instr_count++;
		end
		else if (m_cycle == CYC_BRK_HALT)
		begin
			halt_count++;
			if (halt_count == 3)
				pc = pc ^ ADDR_W'(1);	// Move off the breakpoint
		end
	endtask

	task automatic check_outputs();
		string tag;
		tag = $sformatf("instr %0d %s", instr_count, m_cycle.name());
		check_cycle({tag, " cycle"}, m_cycle, cycle);
		check_ctrl({tag, " ctrl"}, expected_ctrl(m_cycle, m_instr, cex_allows(m_cex), psw_in),
			ctrl);
		check_psw({tag, " psw"}, m_psw, psw_out);
		check_cex({tag, " cex"}, m_cex, cex_state);
	endtask

	task automatic advance_model();
		logic ok;
		logic [4:0] flags;
		cycle_t stop;
		ok = cex_allows(m_cex);
		stop = (pc == brkpnt) ? CYC_BRK_HALT : CYC_FETCH;
		flags = psw_in[4:0];
		if ((m_cycle == CYC_EXEC1) && (m_instr.op == OP_SETCC))
			flags = flags | m_instr.pswb;
		else if ((m_cycle == CYC_EXEC1) && (m_instr.op == OP_CLRCC))
			flags = flags & ~m_instr.pswb;
		m_psw = {psw_in[15:5], flags};	// One cycle behind psw_in
		case (m_cycle)
			CYC_FETCH: m_cycle = CYC_FETCH_PC;
			CYC_FETCH_PC: m_cycle = CYC_FETCH_IR;
			CYC_FETCH_IR: m_cycle = CYC_DECODE;
			CYC_DECODE:
			begin
				if (ok)
					m_instr = instr;
				m_cex = cex_after_decode(m_cex);
				m_cycle = ok ? CYC_EXEC1 : stop;	// Skipped instruction ends here
			end
			CYC_EXEC1:
			begin
				if (m_instr.op == OP_CEX)
					m_cex = '{active: 1'b1, result: cond_holds(m_instr.cond, psw_in),
						t_cnt: m_instr.t_cnt, f_cnt: m_instr.f_cnt};
				m_cycle = (m_instr.op == OP_SWAP) ? CYC_EXEC2 : stop;
			end
			CYC_EXEC2: m_cycle = CYC_EXEC3;
			CYC_EXEC3: m_cycle = stop;
			default: m_cycle = (pc != brkpnt) ? CYC_FETCH : CYC_BRK_HALT;
		endcase
	endtask

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		seed = 5757;
		clock = 1'b0;
		cpucycle_rst = 1'b1;
		instr = '0;
		pc = '0;
		brkpnt = '1;
		psw_in = '0;
		cycle_count = 0;
		instr_count = 0;
		halt_count = 0;
		err_cycle = 0;
		err_ctrl = 0;
		err_psw = 0;
		err_cex = 0;
		m_cycle = CYC_FETCH;	// Reset state
		m_instr = '0;
		m_cex = '0;
		m_psw = PSW_INIT;
		repeat (RESET_CYC) @(posedge clock);
		@(negedge clock);
		cpucycle_rst = 1'b0;
		while (!((instr_count == NUM_INSTR) && (m_cycle == CYC_FETCH)))
		begin
			drive_inputs();
			#1;	// Let combinational outputs settle
			check_outputs();
			advance_model();
			@(negedge clock);
		end
		err_total = err_cycle + err_ctrl + err_psw + err_cex;
		$display("Errors: %0d total, cycle %0d, ctrl %0d, psw %0d, cex %0d",
			err_total, err_cycle, err_ctrl, err_psw, err_cex);
		if (err_total == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* tb.f */
cu_pkg.sv
condition_eval.sv
cex_tracker.sv
cycle_sequencer.sv
psw_unit.sv
exec_control.sv
control_unit.sv
tb_control_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_control_unit
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
